/* cam_pkg.sv */
package cam_pkg;

  // one byte as it appears on the parallel camera bus
  typedef logic [7:0] cam_byte_t;

  // reconstructed pixel with red in [15:11], green in [10:5] and blue in [4:0]
  typedef logic [15:0] rgb565_t;

  // column within a line wide enough for 1280
  typedef logic [10:0] hcount_t;

  // row within a frame wide enough for 720
  typedef logic [9:0] vcount_t;

  // one pixel leaving the capture stage with valid as a single-cycle strobe
  typedef struct packed {
    logic    valid;
    hcount_t hcount;
    vcount_t vcount;
    rgb565_t data;
  } cam_pixel_s;

endpackage

/* track_pkg.sv */
package track_pkg;

  // channel picked for thresholding with the same codes as the switch encoding
  typedef enum logic [1:0] {
    ch_green = 2'b00,
    ch_red   = 2'b01,
    ch_blue  = 2'b10
  } channel_e;

  // channel value widened to 8 bits, also used for both thresholds
  typedef logic [7:0] level_t;

  // thresholded pixel with its coordinates
  typedef struct packed {
    logic             valid;
    cam_pkg::hcount_t hcount;
    cam_pkg::vcount_t vcount;
    logic             mask;
  } mask_pixel_s;

  // center of mass in pixel coordinates
  typedef struct packed {
    cam_pkg::hcount_t x;
    cam_pkg::vcount_t y;
  } com_s;

endpackage

/* camera_capture.sv */
`timescale 1ns/1ps

module camera_capture #(
  parameter int FRAME_W = 1280,
  parameter int FRAME_H = 720
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  cam_pkg::cam_byte_t  camera_d_i,
  input  logic                cam_pclk_i,
  input  logic                cam_hsync_i,
  input  logic                cam_vsync_i,
  output cam_pkg::cam_pixel_s pixel_o,
  output logic                frame_end_o
);
  import cam_pkg::*;

  // two flops per input with bit 1 as the synced copy
  cam_byte_t  d_meta;
  cam_byte_t  d_sync;
  logic [1:0] pclk_sync;
  logic [1:0] hsync_sync;
  logic [1:0] vsync_sync;
  // previous synced samples for edge detection
  logic       pclk_prev;
  logic       hsync_prev;
  logic       vsync_prev;
  logic       pclk_rise;
  logic       hsync_fall;
  logic       vsync_rise;
  logic       take_byte;
  // 0 while waiting for the high byte of a pair
  logic       byte_phase;
  cam_byte_t  hi_byte;
  hcount_t    hcount_q;
  vcount_t    vcount_q;
  logic       in_frame;

  assign pclk_rise  = pclk_sync[1] & ~pclk_prev;
  assign hsync_fall = ~hsync_sync[1] & hsync_prev;
  assign vsync_rise = vsync_sync[1] & ~vsync_prev;
  // bytes only count while hsync marks the line active
  assign take_byte  = pclk_rise & hsync_sync[1];
  // pixels past the nominal frame size are dropped
  assign in_frame   = (int'(hcount_q) < FRAME_W) && (int'(vcount_q) < FRAME_H);

  // data bus synchronizer
  always_ff @(posedge clk_camera) begin
    d_meta <= camera_d_i;
    d_sync <= d_meta;
  end

  // control synchronizers and edge history
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_sync  <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
      pclk_prev  <= 1'b0;
      hsync_prev <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], cam_pclk_i};
      hsync_sync <= {hsync_sync[0], cam_hsync_i};
      vsync_sync <= {vsync_sync[0], cam_vsync_i};
      pclk_prev  <= pclk_sync[1];
      hsync_prev <= hsync_sync[1];
      vsync_prev <= vsync_sync[1];
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      byte_phase    <= 1'b0;
      hcount_q      <= '0;
      vcount_q      <= '0;
      pixel_o.valid <= 1'b0;
      frame_end_o   <= 1'b0;
    end else begin
      pixel_o.valid <= 1'b0;
      frame_end_o   <= vsync_rise;
      if (vsync_rise) begin
        // new frame starts from the top row
        hcount_q   <= '0;
        vcount_q   <= '0;
        byte_phase <= 1'b0;
      end else if (hsync_fall) begin
        // end of line
        hcount_q   <= '0;
        vcount_q   <= vcount_q + 1'b1;
        byte_phase <= 1'b0;
      end else if (take_byte) begin
        byte_phase <= ~byte_phase;
        if (!byte_phase) begin
          hi_byte <= d_sync;
        end else begin
          // low byte completes the pixel
          pixel_o.valid  <= in_frame;
          pixel_o.hcount <= hcount_q;
          pixel_o.vcount <= vcount_q;
          pixel_o.data   <= {hi_byte, d_sync};
          hcount_q       <= hcount_q + 1'b1;
        end
      end
    end
  end

endmodule

/* channel_threshold.sv */
`timescale 1ns/1ps

module channel_threshold (
  input  logic                  clk_camera,
  input  logic                  recent_reset,
  input  cam_pkg::cam_pixel_s   pixel_i,
  input  track_pkg::channel_e   channel_sel_i,
  input  track_pkg::level_t     lower_i,
  input  track_pkg::level_t     upper_i,
  output track_pkg::mask_pixel_s mask_o
);
  import track_pkg::*;

  level_t level;
  logic   in_range;

  // widen the chosen field, zeros go in at the bottom
  always_comb begin
    case (channel_sel_i)
      ch_red:   level = {pixel_i.data[15:11], 3'b000};
      ch_green: level = {pixel_i.data[10:5], 2'b00};
      ch_blue:  level = {pixel_i.data[4:0], 3'b000};
      default:  level = '0;
    endcase
  end

  // both bounds are inclusive
  assign in_range = (level >= lower_i) && (level <= upper_i);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      mask_o.valid <= 1'b0;
    end else begin
      mask_o.valid  <= pixel_i.valid;
      mask_o.hcount <= pixel_i.hcount;
      mask_o.vcount <= pixel_i.vcount;
      mask_o.mask   <= in_range;
    end
  end

endmodule

/* centroid_tracker.sv */
`timescale 1ns/1ps

module centroid_tracker #(
  parameter int FRAME_W = 1280,
  parameter int FRAME_H = 720
) (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  track_pkg::mask_pixel_s mask_i,
  input  logic                   frame_end_i,
  output logic                   com_valid_o,
  output track_pkg::com_s        com_o
);
  import cam_pkg::*;

  // sum bounds taken as if every pixel sat on the far edge
  localparam int XSUM_W = $clog2(longint'(FRAME_W) * FRAME_H * FRAME_W);
  localparam int YSUM_W = $clog2(longint'(FRAME_W) * FRAME_H * FRAME_H);
  localparam int CNT_W  = $clog2(FRAME_W * FRAME_H + 1);
  // one divider width serves both sums
  localparam int DIV_W  = (XSUM_W > YSUM_W) ? XSUM_W : YSUM_W;
  localparam int STEP_W = $clog2(DIV_W + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_div_x,
    st_div_y,
    st_done
  } state_e;

  state_e              state_q;
  logic [XSUM_W-1:0]   xsum_q;
  logic [YSUM_W-1:0]   ysum_q;
  logic [CNT_W-1:0]    cnt_q;
  logic                hit;
  // operands held for the whole division
  logic [YSUM_W-1:0]   ysum_lat;
  logic [CNT_W-1:0]    cnt_lat;
  // dividend shifts out at the top, quotient bits enter at the bottom
  logic [DIV_W-1:0]    num_q;
  logic [CNT_W-1:0]    rem_q;
  logic [STEP_W-1:0]   step_q;
  logic [CNT_W:0]      trial;
  logic [CNT_W:0]      diff;
  logic                fits;
  logic                last_step;
  hcount_t             x_res;

  assign hit       = mask_i.valid & mask_i.mask;
  assign trial     = {rem_q, num_q[DIV_W-1]};
  assign diff      = trial - {1'b0, cnt_lat};
  assign fits      = trial >= {1'b0, cnt_lat};
  assign last_step = step_q == STEP_W'(DIV_W - 1);
  assign com_valid_o = state_q == st_done;

  // per-frame accumulators where a pixel landing on frame_end opens the new frame
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      xsum_q <= '0;
      ysum_q <= '0;
      cnt_q  <= '0;
    end else begin
      xsum_q <= (frame_end_i ? '0 : xsum_q) + (hit ? XSUM_W'(mask_i.hcount) : '0);
      ysum_q <= (frame_end_i ? '0 : ysum_q) + (hit ? YSUM_W'(mask_i.vcount) : '0);
      cnt_q  <= (frame_end_i ? '0 : cnt_q) + CNT_W'(hit);
    end
  end

  // restoring divider that takes x first and then y
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state_q <= st_idle;
      step_q  <= '0;
      com_o   <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          // empty frame leaves the last result in place
          if (frame_end_i && cnt_q != '0) begin
            num_q    <= DIV_W'(xsum_q);
            ysum_lat <= ysum_q;
            cnt_lat  <= cnt_q;
            rem_q    <= '0;
            step_q   <= '0;
            state_q  <= st_div_x;
          end
        end
        st_div_x, st_div_y: begin
          rem_q  <= fits ? diff[CNT_W-1:0] : trial[CNT_W-1:0];
          num_q  <= {num_q[DIV_W-2:0], fits};
          step_q <= step_q + 1'b1;
          if (last_step) begin
            step_q <= '0;
            rem_q  <= '0;
            if (state_q == st_div_x) begin
              x_res   <= hcount_t'({num_q[DIV_W-2:0], fits});
              num_q   <= DIV_W'(ysum_lat);
              state_q <= st_div_y;
            end else begin
              com_o.x <= x_res;
              com_o.y <= vcount_t'({num_q[DIV_W-2:0], fits});
              state_q <= st_done;
            end
          end
        end
        // one cycle of com_valid_o
        st_done: state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

/* frame_subsampler.sv */
`timescale 1ns/1ps

module frame_subsampler #(
  parameter int FRAME_W   = 1280,
  parameter int FRAME_H   = 720,
  parameter int SUBSAMPLE = 4
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  cam_pkg::cam_pixel_s pixel_i,
  output logic                fb_we_o,
  output logic [$clog2((FRAME_W / SUBSAMPLE) * (FRAME_H / SUBSAMPLE)) - 1:0] fb_addr_o,
  output cam_pkg::rgb565_t    fb_data_o
);

  localparam int FB_W  = FRAME_W / SUBSAMPLE;
  localparam int FB_AW = $clog2(FB_W * (FRAME_H / SUBSAMPLE));

  logic keep;

  // keep the top left pixel of each SUBSAMPLE x SUBSAMPLE block
  assign keep = pixel_i.valid
              && (pixel_i.hcount % SUBSAMPLE == 0)
              && (pixel_i.vcount % SUBSAMPLE == 0);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      fb_we_o <= 1'b0;
    end else begin
      fb_we_o <= keep;
      if (keep) begin
        // row major address in the reduced buffer
        fb_addr_o <= FB_AW'((pixel_i.vcount / SUBSAMPLE) * FB_W + pixel_i.hcount / SUBSAMPLE);
        fb_data_o <= pixel_i.data;
      end
    end
  end

endmodule

/* camera_tracker_top.sv */
`timescale 1ns/1ps

module camera_tracker_top #(
  parameter int FRAME_W   = 1280,
  parameter int FRAME_H   = 720,
  parameter int SUBSAMPLE = 4
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  // parallel camera bus
  input  cam_pkg::cam_byte_t  camera_d_i,
  input  logic                cam_pclk_i,
  input  logic                cam_hsync_i,
  input  logic                cam_vsync_i,
  // threshold controls
  input  track_pkg::channel_e channel_sel_i,
  input  track_pkg::level_t   lower_i,
  input  track_pkg::level_t   upper_i,
  // frame buffer write port
  output logic                fb_we_o,
  output logic [$clog2((FRAME_W / SUBSAMPLE) * (FRAME_H / SUBSAMPLE)) - 1:0] fb_addr_o,
  output cam_pkg::rgb565_t    fb_data_o,
  // center of mass result
  output logic                com_valid_o,
  output track_pkg::com_s     com_o
);
  import cam_pkg::*;
  import track_pkg::*;

  cam_pixel_s  pixel;
  logic        frame_end;
  mask_pixel_s mask;

  camera_capture #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) i_capture (
    .clk_camera, .recent_reset, .camera_d_i, .cam_pclk_i, .cam_hsync_i, .cam_vsync_i,
    .pixel_o(pixel), .frame_end_o(frame_end));

  channel_threshold i_threshold (
    .clk_camera, .recent_reset, .pixel_i(pixel), .channel_sel_i, .lower_i, .upper_i,
    .mask_o(mask));

  // tracker sees the same frame_end as the capture stage raised it
  centroid_tracker #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) i_tracker (
    .clk_camera, .recent_reset, .mask_i(mask), .frame_end_i(frame_end),
    .com_valid_o, .com_o);

  frame_subsampler #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .SUBSAMPLE(SUBSAMPLE)) i_subsampler (
    .clk_camera, .recent_reset, .pixel_i(pixel), .fb_we_o, .fb_addr_o, .fb_data_o);

endmodule

/* camera_tracker_assertions.sv */
`timescale 1ns/1ps

module camera_tracker_assertions #(
  parameter int FRAME_W   = 1280,
  parameter int FRAME_H   = 720,
  parameter int SUBSAMPLE = 4
) (
  input logic clk_camera,
  input logic recent_reset,
  input logic fb_we_o,
  input logic [$clog2((FRAME_W / SUBSAMPLE) * (FRAME_H / SUBSAMPLE)) - 1:0] fb_addr_o,
  input logic com_valid_o
);

  localparam int FB_DEPTH = (FRAME_W / SUBSAMPLE) * (FRAME_H / SUBSAMPLE);

  // a pixel spans several camera clocks, so writes never touch
  fb_we_single: assert property (@(posedge clk_camera) disable iff (recent_reset)
    fb_we_o |=> !fb_we_o)
    else $error("fb_we_o high on two consecutive cycles");

  // result strobe lasts one cycle
  com_valid_single: assert property (@(posedge clk_camera) disable iff (recent_reset)
    com_valid_o |=> !com_valid_o)
    else $error("com_valid_o high on two consecutive cycles");

  fb_addr_range: assert property (@(posedge clk_camera) disable iff (recent_reset)
    fb_we_o |-> (int'(fb_addr_o) < FB_DEPTH))
    else $error("fb_addr_o outside the frame buffer");

endmodule

bind camera_tracker_top camera_tracker_assertions #(
  .FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .SUBSAMPLE(SUBSAMPLE)
) i_assertions (
  .clk_camera(clk_camera), .recent_reset(recent_reset), .fb_we_o(fb_we_o),
  .fb_addr_o(fb_addr_o), .com_valid_o(com_valid_o)
);

/* tb_camera_tracker.sv */
`timescale 1ns/1ps

module tb_camera_tracker;
  import cam_pkg::*;
  import track_pkg::*;

  localparam int FRAME_W          = 32;
  localparam int FRAME_H          = 16;
  localparam int SUBSAMPLE        = 4;
  localparam int FB_AW            = $clog2((FRAME_W / SUBSAMPLE) * (FRAME_H / SUBSAMPLE));
  localparam int WRITES_PER_FRAME = (FRAME_W / SUBSAMPLE) * (FRAME_H / SUBSAMPLE);
  // idle cycles with hsync low after each line
  localparam int LINE_GAP         = 8;
  // vsync pulse plus lines where each byte spans 4 clocks
  localparam int FRAME_CYCLES     = 8 + FRAME_H * (FRAME_W * 8 + LINE_GAP);
  localparam int NUM_FRAMES       = 8;
  localparam int COM_TIMEOUT      = 200;
  localparam int SETTLE           = 40;
  localparam int WATCHDOG_CYCLES  = NUM_FRAMES * FRAME_CYCLES + 2000;
  // frame fill patterns
  localparam int FILL_RANDOM      = 0;
  localparam int FILL_REGIONS     = 1;
  localparam int FILL_BOUNDS      = 2;

  logic             clk_camera;
  logic             recent_reset;
  cam_byte_t        camera_d_i;
  logic             cam_pclk_i;
  logic             cam_hsync_i;
  logic             cam_vsync_i;
  channel_e         channel_sel_i;
  level_t           lower_i;
  level_t           upper_i;
  logic             fb_we_o;
  logic [FB_AW-1:0] fb_addr_o;
  rgb565_t          fb_data_o;
  logic             com_valid_o;
  com_s             com_o;

  // pixels of the frame being sent indexed by row then column
  rgb565_t          frame_pix [FRAME_H][FRAME_W];
  logic [FB_AW-1:0] exp_addr_q [$];
  rgb565_t          exp_data_q [$];
  com_s             exp_com_q [$];
  com_s             exp_com;
  integer           seed;
  int               errors;
  int               checks;
  int               err_base;
  int               fb_seen;
  int               com_seen;
  int               com_expected;
  int               frames_in_test;

  camera_tracker_top #(
    .FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .SUBSAMPLE(SUBSAMPLE)
  ) i_dut (
    .clk_camera(clk_camera), .recent_reset(recent_reset), .camera_d_i(camera_d_i),
    .cam_pclk_i(cam_pclk_i), .cam_hsync_i(cam_hsync_i), .cam_vsync_i(cam_vsync_i),
    .channel_sel_i(channel_sel_i), .lower_i(lower_i), .upper_i(upper_i),
    .fb_we_o(fb_we_o), .fb_addr_o(fb_addr_o), .fb_data_o(fb_data_o),
    .com_valid_o(com_valid_o), .com_o(com_o)
  );

  initial begin
    clk_camera = 1'b0;
    forever #10 clk_camera = ~clk_camera;
  end

  // channel field scaled to 8 bits with zero low bits
  function automatic level_t level_ref(input rgb565_t pix, input channel_e ch);
    if (ch == ch_red) return level_t'(pix[15:11]) << 3;
    if (ch == ch_green) return level_t'(pix[10:5]) << 2;
    return level_t'(pix[4:0]) << 3;
  endfunction

  // inclusive window on the scaled field
  function automatic logic mask_ref(input rgb565_t pix, input channel_e ch,
                                    input level_t lo, input level_t hi);
    level_t lvl;
    lvl = level_ref(pix, ch);
    return (lvl >= lo) && (lvl <= hi);
  endfunction

  function automatic int addr_ref(input int h, input int v);
    return (v / SUBSAMPLE) * (FRAME_W / SUBSAMPLE) + h / SUBSAMPLE;
  endfunction

  // bit 21 set when any pixel passes and low bits hold floor of sum over count
  function automatic logic [21:0] centroid_ref(input channel_e ch, input level_t lo,
                                               input level_t hi);
    int sx;
    int sy;
    int n;
    sx = 0;
    sy = 0;
    n = 0;
    for (int v = 0; v < FRAME_H; v++) begin
      for (int h = 0; h < FRAME_W; h++) begin
        if (mask_ref(frame_pix[v][h], ch, lo, hi)) begin
          sx += h;
          sy += v;
          n++;
        end
      end
    end
    if (n == 0) return '0;
    return {1'b1, hcount_t'(sx / n), vcount_t'(sy / n)};
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  task automatic drive_cycles(input int n);
    repeat (n) @(negedge clk_camera);
  endtask

  // 2 clocks with pclk low and then 2 with pclk high
  task automatic send_byte(input cam_byte_t b);
    camera_d_i = b;
    cam_pclk_i = 1'b0;
    drive_cycles(2);
    cam_pclk_i = 1'b1;
    drive_cycles(2);
  endtask

  task automatic vsync_pulse();
    cam_vsync_i = 1'b1;
    drive_cycles(4);
    cam_vsync_i = 1'b0;
    drive_cycles(4);
  endtask

  task automatic fill_frame(input int kind);
    for (int v = 0; v < FRAME_H; v++) begin
      for (int h = 0; h < FRAME_W; h++) begin
        frame_pix[v][h] = '0;
        if (kind == FILL_RANDOM) frame_pix[v][h] = rgb565_t'($random(seed));
        // red left band, green top band, blue lower right block
        if (kind == FILL_REGIONS) begin
          if (h < 8) frame_pix[v][h] = frame_pix[v][h] | 16'hF800;
          if (v < 4) frame_pix[v][h] = frame_pix[v][h] | 16'h07E0;
          if (h >= 24 && v >= 8) frame_pix[v][h] = frame_pix[v][h] | 16'h001F;
        end
      end
    end
    if (kind == FILL_BOUNDS) begin
      // red fields 8 and 20 sit on the window edges while 7 and 21 lie just outside
      frame_pix[2][3]   = {5'd8, 11'd0};
      frame_pix[9][20]  = {5'd20, 11'd0};
      frame_pix[5][10]  = {5'd7, 11'd0};
      frame_pix[14][30] = {5'd21, 11'd0};
    end
  endtask

  task automatic send_frame(input channel_e ch, input level_t lo, input level_t hi);
    logic [21:0] ref_com;
    channel_sel_i = ch;
    lower_i = lo;
    upper_i = hi;
    ref_com = centroid_ref(ch, lo, hi);
    if (ref_com[21]) begin
      exp_com_q.push_back(com_s'(ref_com[20:0]));
      com_expected++;
    end
    for (int v = 0; v < FRAME_H; v++) begin
      for (int h = 0; h < FRAME_W; h++) begin
        if (h % SUBSAMPLE == 0 && v % SUBSAMPLE == 0) begin
          exp_addr_q.push_back(FB_AW'(addr_ref(h, v)));
          exp_data_q.push_back(frame_pix[v][h]);
        end
      end
    end
    vsync_pulse();
    for (int v = 0; v < FRAME_H; v++) begin
      cam_hsync_i = 1'b1;
      for (int h = 0; h < FRAME_W; h++) begin
        // high byte first
        send_byte(frame_pix[v][h][15:8]);
        send_byte(frame_pix[v][h][7:0]);
      end
      cam_pclk_i = 1'b0;
      cam_hsync_i = 1'b0;
      drive_cycles(LINE_GAP);
    end
    frames_in_test++;
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_base);
    err_base = errors;
  endtask

  // closing vsync starts the division of the last frame
  task automatic finish_test(input int num, input string name);
    int cycles;
    vsync_pulse();
    cycles = 0;
    while (exp_com_q.size() != 0 && cycles < COM_TIMEOUT) begin
      drive_cycles(1);
      cycles++;
    end
    if (exp_com_q.size() != 0) begin
      errors++;
      $display("centroid result did not arrive within %0d cycles of the frame end", COM_TIMEOUT);
    end
    // room for any stray pulse to show up
    drive_cycles(SETTLE);
    check_value("fb write count", fb_seen, frames_in_test * WRITES_PER_FRAME);
    check_value("centroid count", com_seen, com_expected);
    check_value("fb writes still pending", exp_addr_q.size(), 0);
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_com_q.delete();
    fb_seen = 0;
    com_seen = 0;
    com_expected = 0;
    frames_in_test = 0;
    report_test(num, name);
  endtask

  // reset lands while a division runs and a pixel is still in the pipeline
  task automatic check_reset();
    fill_frame(FILL_REGIONS);
    send_frame(ch_red, 8'hC0, 8'hFF);
    // the reset below drops the result of this frame
    exp_com_q.delete();
    com_expected = 0;
    vsync_pulse();
    // first pixel of a new line whose low byte is clocked as reset rises
    cam_hsync_i = 1'b1;
    send_byte(8'hAB);
    camera_d_i = 8'hCD;
    cam_pclk_i = 1'b0;
    drive_cycles(2);
    cam_pclk_i = 1'b1;
    recent_reset = 1'b1;
    drive_cycles(2);
    recent_reset = 1'b0;
    cam_pclk_i = 1'b0;
    cam_hsync_i = 1'b0;
    repeat (SETTLE) begin
      drive_cycles(1);
      check_value("fb_we_o after reset", fb_we_o, 0);
      check_value("com_valid_o after reset", com_valid_o, 0);
      check_value("com_o after reset", com_o, 0);
    end
    check_value("fb writes still pending", exp_addr_q.size(), 0);
    report_test(5, "reset");
  endtask

  // every write and result is matched in order against the expected queues
  always @(negedge clk_camera) begin
    if (fb_we_o) begin
      fb_seen++;
      if (exp_addr_q.size() == 0) begin
        errors++;
        $display("unexpected frame buffer write at %0t ns", $time);
      end else begin
        check_value("fb address", fb_addr_o, exp_addr_q.pop_front());
        check_value("fb data", fb_data_o, exp_data_q.pop_front());
      end
    end
    if (com_valid_o) begin
      com_seen++;
      if (exp_com_q.size() == 0) begin
        errors++;
        $display("unexpected centroid result at %0t ns", $time);
      end else begin
        exp_com = exp_com_q.pop_front();
        check_value("centroid x", com_o.x, exp_com.x);
        check_value("centroid y", com_o.y, exp_com.y);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_camera);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    recent_reset = 1'b1;
    camera_d_i = '0;
    cam_pclk_i = 1'b0;
    cam_hsync_i = 1'b0;
    cam_vsync_i = 1'b0;
    channel_sel_i = ch_red;
    lower_i = '0;
    upper_i = '0;
    seed = 32'h6a84ae32;
    errors = 0;
    checks = 0;
    err_base = 0;
    fb_seen = 0;
    com_seen = 0;
    com_expected = 0;
    frames_in_test = 0;
    drive_cycles(2);
    recent_reset = 1'b0;
    drive_cycles(4);

    for (int f = 0; f < 2; f++) begin
      fill_frame(FILL_RANDOM);
      send_frame(ch_green, 8'h00, 8'h7F);
    end
    finish_test(1, "pixel reconstruction and subsampling");

    fill_frame(FILL_REGIONS);
    send_frame(ch_red, 8'hC0, 8'hFF);
    send_frame(ch_green, 8'hC0, 8'hFF);
    send_frame(ch_blue, 8'hC0, 8'hFF);
    finish_test(2, "channel choice");

    fill_frame(FILL_BOUNDS);
    send_frame(ch_red, 8'h40, 8'hA0);
    finish_test(3, "threshold bounds");

    // blue tops out at 0xF8, so nothing passes
    fill_frame(FILL_RANDOM);
    send_frame(ch_blue, 8'hF9, 8'hFF);
    finish_test(4, "empty mask");

    check_reset();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* camera_tracker.f */
cam_pkg.sv
track_pkg.sv
camera_capture.sv
channel_threshold.sv
centroid_tracker.sv
frame_subsampler.sv
camera_tracker_top.sv
camera_tracker_assertions.sv
tb_camera_tracker.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_camera_tracker -f camera_tracker.f -o sim_camera_tracker

output="$(./obj_dir/sim_camera_tracker 2>&1)" || {
  echo "$output"
  echo "simulation exited with an error"
  exit 1
}
echo "$output"

if grep -q '^TEST PASSED$' <<< "$output"; then
  exit 0
fi
exit 1
